// File: mm_dot.f
+incdir+hw
hw/mm_dot_pkg.sv
hw/mm_dot_ifs.sv
hw/mm_dot_csr.sv
hw/mm_dot_requestor.sv
hw/mm_dot_operand_queue.sv
hw/mm_dot_pe.sv
hw/mm_dot_top.sv
sim/mm_dot_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing
TOP       := mm_dot_tb
RTL_TOP   := mm_dot_top
FILELIST  := mm_dot.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Testbench passed
SOURCES   := $(wildcard hw/*.sv hw/*.svh sim/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/mm_dot_tb.sv
`include "mm_dot_macros.svh"

module mm_dot_tb import mm_dot_pkg::*;
();

	localparam int N_ROWS = 6;
	localparam int MAX_ELEMS = 256;
	localparam int DONE_LIMIT = 4000;   // Cycles per job

	logic Clk_400;
	logic rst;
	logic mmio_wr_valid;
	logic mmio_rd_valid;
	t_mmio_addr mmio_addr;
	t_mmio_data mmio_wdata;
	logic [8:0] mmio_tid;
	logic mmio_rsp_valid;
	logic [8:0] mmio_rsp_tid;
	t_mmio_data mmio_rsp_data;
	logic rd_req_valid;
	t_addr rd_req_addr;
	t_tag rd_req_tag;
	logic rd_almfull;
	logic rd_rsp_valid;
	t_tag rd_rsp_tag;
	t_elem rd_rsp_data;
	logic done;

	integer seed = 32'hc8fb_6bbc;
	int errors = 0;
	int done_cnt = 0;
	int req_cnt = 0;
	int almfull_rate = 0;   // Percent of cycles with rd_almfull high
	int cyc = 0;

	// Running job, seen by the request monitor
	t_addr job_src_a;
	t_addr job_src_b;
	int job_num;
	bit seen_a [MAX_ELEMS];
	bit seen_b [MAX_ELEMS];

	// --------------------
	// Test table
	// --------------------
	t_addr row_src_a [N_ROWS];
	t_addr row_src_b [N_ROWS];
	int row_num [N_ROWS];
	int row_rate [N_ROWS];
	bit row_restart [N_ROWS];   // Second CTL write while busy
	t_acc row_exp [N_ROWS];

	// Outstanding reads in the memory model
	t_tag mem_tag_q [$];
	t_addr mem_addr_q [$];
	int mem_due_q [$];

	mm_dot_top DUT
	(
		.Clk_400        (Clk_400),
		.rst            (rst),
		.mmio_wr_valid  (mmio_wr_valid),
		.mmio_rd_valid  (mmio_rd_valid),
		.mmio_addr      (mmio_addr),
		.mmio_wdata     (mmio_wdata),
		.mmio_tid       (mmio_tid),
		.mmio_rsp_valid (mmio_rsp_valid),
		.mmio_rsp_tid   (mmio_rsp_tid),
		.mmio_rsp_data  (mmio_rsp_data),
		.rd_req_valid   (rd_req_valid),
		.rd_req_addr    (rd_req_addr),
		.rd_req_tag     (rd_req_tag),
		.rd_almfull     (rd_almfull),
		.rd_rsp_valid   (rd_rsp_valid),
		.rd_rsp_tag     (rd_rsp_tag),
		.rd_rsp_data    (rd_rsp_data),
		.done           (done)
	);

	initial
	begin
		Clk_400 = 1'b0;
		forever #10 Clk_400 = ~Clk_400;
	end

	// Host memory contents
	function automatic t_elem mem_word(input t_addr addr);
		return addr * 32'd3 + 32'd1 - 32'h4000_0000;
	endfunction

	function automatic t_acc dot_expected(input t_addr sa, input t_addr sb, input int n);
		longint sum;
		sum = 0;
		for (int i = 0; i < n; i++)
			sum += longint'($signed(mem_word(sa + 4 * i))) * longint'($signed(mem_word(sb + 4 * i)));
		return t_acc'(sum);   // Wraps at 64 bits
	endfunction

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
		if (got !== exp)
		begin
			$display("FAIL %0t: %s, got %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	task automatic set_row(input int r, input t_addr sa, input t_addr sb, input int n,
		input int rate, input bit restart);
		row_src_a[r] = sa;
		row_src_b[r] = sb;
		row_num[r] = n;
		row_rate[r] = rate;
		row_restart[r] = restart;
		row_exp[r] = dot_expected(sa, sb, n);
	endtask

	task automatic load_table();
		set_row(0, 32'h0000_1000, 32'h0000_2000, 8, 0, 1'b0);
		set_row(1, 32'h0001_0000, 32'h0002_0400, 32, 30, 1'b0);
		set_row(2, 32'h4000_0000, 32'h8000_0010, 17, 60, 1'b0);
		set_row(3, 32'h0000_3000, 32'h0000_5000, 0, 20, 1'b0);   // Empty job
		set_row(4, 32'h0000_7ff0, 32'h0001_8000, 24, 10, 1'b1);
		set_row(5, 32'hffff_ff00, 32'h0000_0100, 50, 40, 1'b0);
	endtask

	// --------------------
	// MMIO access
	// --------------------
	task automatic mmio_write(input t_mmio_addr addr, input t_mmio_data data);
		@(posedge Clk_400);
		mmio_wr_valid <= 1'b1;
		mmio_addr <= addr;
		mmio_wdata <= data;
		@(posedge Clk_400);
		mmio_wr_valid <= 1'b0;
	endtask

	task automatic mmio_read(input t_mmio_addr addr, input logic [8:0] tid,
		output t_mmio_data data);
		@(posedge Clk_400);
		mmio_rd_valid <= 1'b1;
		mmio_addr <= addr;
		mmio_tid <= tid;
		@(posedge Clk_400);     // DUT takes the read here
		mmio_rd_valid <= 1'b0;
		check(mmio_rsp_valid, 0, "mmio_rsp_valid in the read cycle");
		@(posedge Clk_400);
		check(mmio_rsp_valid, 1, "mmio_rsp_valid one cycle after the read");
		check(mmio_rsp_tid, tid, "mmio_rsp_tid");
		data = mmio_rsp_data;
	endtask

	task automatic wait_done(input int r, input int done_base);
		int waited;
		waited = 0;
		while (done_cnt == done_base && waited < DONE_LIMIT)
		begin
			@(posedge Clk_400);
			waited++;
		end
		if (done_cnt == done_base)
		begin
			$display("Row %0d: no done pulse within %0d cycles", r, DONE_LIMIT);
			errors++;
		end
	endtask

	task automatic run_row(input int r);
		t_mmio_data rdata;
		int done_base;
		job_src_a = row_src_a[r];
		job_src_b = row_src_b[r];
		job_num = row_num[r];
		for (int i = 0; i < MAX_ELEMS; i++)
		begin
			seen_a[i] = 1'b0;
			seen_b[i] = 1'b0;
		end
		req_cnt = 0;
		almfull_rate = row_rate[r];
		mmio_write(`MM_REG_SRC_A, 64'(row_src_a[r]));
		mmio_write(`MM_REG_SRC_B, 64'(row_src_b[r]));
		mmio_write(`MM_REG_NUM, 64'(row_num[r]));
		done_base = done_cnt;
		mmio_write(`MM_REG_CTL, 64'h1);
		if (row_restart[r])
		begin
			repeat (4) @(posedge Clk_400);
			mmio_write(`MM_REG_CTL, 64'h1);     // Must be dropped
		end
		wait_done(r, done_base);
		repeat (8) @(posedge Clk_400);
		check(done_cnt - done_base, 1, $sformatf("row %0d done pulse count", r));
		check(req_cnt, 2 * row_num[r], $sformatf("row %0d read request count", r));
		mmio_read(`MM_REG_STATUS, 9'(9'h040 + r), rdata);
		check(rdata, 64'h2, $sformatf("row %0d STATUS done and not busy", r));
		mmio_read(`MM_REG_RESULT, 9'(9'h080 + r), rdata);
		check(rdata, row_exp[r], $sformatf("row %0d RESULT", r));
		almfull_rate = 0;
	endtask

	// --------------------
	// Read channel model
	// --------------------
	always @(posedge Clk_400)
	begin
		int delay;
		if (rst)
		begin
			rd_rsp_valid <= 1'b0;
			rd_almfull <= 1'b0;
			mem_tag_q.delete();
			mem_addr_q.delete();
			mem_due_q.delete();
		end
		else
		begin
			cyc = cyc + 1;
			if (rd_req_valid)
			begin
				delay = 1 + int'({$random(seed)} % 4);
				mem_tag_q.push_back(rd_req_tag);
				mem_addr_q.push_back(rd_req_addr);
				mem_due_q.push_back(cyc + delay);
			end
			// In order, so each operand returns in issue order
			if (mem_due_q.size() != 0 && mem_due_q[0] <= cyc)
			begin
				rd_rsp_valid <= 1'b1;
				rd_rsp_tag <= mem_tag_q.pop_front();
				rd_rsp_data <= mem_word(mem_addr_q.pop_front());
				void'(mem_due_q.pop_front());
			end
			else
				rd_rsp_valid <= 1'b0;
			rd_almfull <= ({$random(seed)} % 100) < almfull_rate;
		end
	end

	// Every request is a fresh element of the running job
	always @(posedge Clk_400)
	begin
		int idx;
		if (!rst && rd_req_valid)
		begin
			idx = int'(rd_req_tag[15:0]);
			req_cnt++;
			check(rd_almfull, 0, "read request while rd_almfull high");
			check(idx < job_num, 1, $sformatf("request index %0d out of range", idx));
			check(rd_req_addr, (rd_req_tag[16] ? job_src_b : job_src_a) + t_addr'(4 * idx),
				"read request address");
			if (idx < MAX_ELEMS)
			begin
				if (rd_req_tag[16])
				begin
					check(seen_b[idx], 0, $sformatf("B element %0d requested twice", idx));
					seen_b[idx] = 1'b1;
				end
				else
				begin
					check(seen_a[idx], 0, $sformatf("A element %0d requested twice", idx));
					seen_a[idx] = 1'b1;
				end
			end
		end
	end

	always @(posedge Clk_400)
	begin
		if (!rst && done)
			done_cnt <= done_cnt + 1;
	end

	// Watchdog, sized from the table
	initial
	begin
		int limit;
		#1;
		limit = 2000;
		for (int r = 0; r < N_ROWS; r++)
			limit += row_num[r] * 40;
		repeat (limit) @(posedge Clk_400);
		$display("Watchdog expired after %0d cycles, the run did not finish", limit);
		$display("Testbench failed");
		$finish;
	end

	initial
	begin
		t_mmio_data rdata;
		rst = 1'b1;
		mmio_wr_valid = 1'b0;
		mmio_rd_valid = 1'b0;
		mmio_addr = '0;
		mmio_wdata = '0;
		mmio_tid = '0;
		rd_almfull = 1'b0;
		rd_rsp_valid = 1'b0;
		rd_rsp_tag = '0;
		rd_rsp_data = '0;
		load_table();
		repeat (16) @(posedge Clk_400);
		rst <= 1'b0;
		@(posedge Clk_400);

		// Quiet after reset
		check(rd_req_valid, 0, "rd_req_valid after reset");
		check(mmio_rsp_valid, 0, "mmio_rsp_valid after reset");
		check(done, 0, "done after reset");
		mmio_read(`MM_REG_STATUS, 9'h011, rdata);
		check(rdata, 0, "STATUS after reset");
		mmio_read(`MM_REG_RESULT, 9'h012, rdata);
		check(rdata, 0, "RESULT after reset");

		// Register readback
		mmio_write(`MM_REG_SRC_A, 64'h89ab_cdef);
		mmio_write(`MM_REG_SRC_B, 64'h1357_9bdf);
		mmio_write(`MM_REG_NUM, 64'h00c3);
		mmio_read(`MM_REG_SRC_A, 9'h0a1, rdata);
		check(rdata, 64'h89ab_cdef, "SRC_A readback");
		mmio_read(`MM_REG_SRC_B, 9'h1b2, rdata);
		check(rdata, 64'h1357_9bdf, "SRC_B readback");
		mmio_read(`MM_REG_NUM, 9'h0c3, rdata);
		check(rdata, 64'h00c3, "NUM readback");

		for (int r = 0; r < N_ROWS; r++)
			run_row(r);

		$display("Run complete, %0d errors", errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: hw/mm_dot_top.sv
module mm_dot_top import mm_dot_pkg::*;
(
	input logic Clk_400,
	input logic rst,
	// Host MMIO
	input logic mmio_wr_valid,
	input logic mmio_rd_valid,
	input t_mmio_addr mmio_addr,
	input t_mmio_data mmio_wdata,
	input logic [8:0] mmio_tid,
	output logic mmio_rsp_valid,
	output logic [8:0] mmio_rsp_tid,
	output t_mmio_data mmio_rsp_data,
	// Read channel
	output logic rd_req_valid,
	output t_addr rd_req_addr,
	output t_tag rd_req_tag,
	input logic rd_almfull,
	input logic rd_rsp_valid,
	input t_tag rd_rsp_tag,
	input t_elem rd_rsp_data,
	output logic done
);

	job_if job ();
	credit_if cred ();

	logic push_a;
	logic push_b;
	t_elem a_head;
	t_elem b_head;

	// Steer responses by the operand bit of the tag
	assign push_a = rd_rsp_valid && !rd_rsp_tag[16];
	assign push_b = rd_rsp_valid && rd_rsp_tag[16];
	assign done = job.done;

	mm_dot_csr csr
	(
		.Clk_400        (Clk_400),
		.rst            (rst),
		.mmio_wr_valid  (mmio_wr_valid),
		.mmio_rd_valid  (mmio_rd_valid),
		.mmio_addr      (mmio_addr),
		.mmio_wdata     (mmio_wdata),
		.mmio_tid       (mmio_tid),
		.mmio_rsp_valid (mmio_rsp_valid),
		.mmio_rsp_tid   (mmio_rsp_tid),
		.mmio_rsp_data  (mmio_rsp_data),
		.job            (job)
	);

	mm_dot_requestor requestor
	(
		.Clk_400        (Clk_400),
		.rst            (rst),
		.job            (job),
		.cred           (cred),
		.rd_req_valid   (rd_req_valid),
		.rd_req_addr    (rd_req_addr),
		.rd_req_tag     (rd_req_tag),
		.rd_almfull     (rd_almfull)
	);

	// --------------------
	// Operand queues
	// --------------------
	mm_dot_operand_queue queue_a
	(
		.Clk_400   (Clk_400),
		.rst       (rst),
		.push      (push_a),
		.push_data (rd_rsp_data),
		.pop       (cred.pop),
		.head      (a_head),
		.count     (cred.a_count),
		.valid     (cred.a_valid)
	);

	mm_dot_operand_queue queue_b
	(
		.Clk_400   (Clk_400),
		.rst       (rst),
		.push      (push_b),
		.push_data (rd_rsp_data),
		.pop       (cred.pop),
		.head      (b_head),
		.count     (cred.b_count),
		.valid     (cred.b_valid)
	);

	mm_dot_pe pe
	(
		.Clk_400 (Clk_400),
		.rst     (rst),
		.job     (job),
		.cred    (cred),
		.a_head  (a_head),
		.b_head  (b_head)
	);

endmodule

// File: hw/mm_dot_pe.sv
module mm_dot_pe import mm_dot_pkg::*;
(
	input logic Clk_400,
	input logic rst,
	job_if.pe job,
	credit_if.pe cred,
	input t_elem a_head,
	input t_elem b_head
);

	t_pe_state state;
	t_count num;
	t_count cnt;        // Pairs accumulated so far
	t_acc acc;
	logic signed [63:0] prod;
	logic take;
	logic last;

	always_comb
	begin
		prod = $signed(a_head) * $signed(b_head);   // Full 64-bit signed product
		take = (state == PE_RUN) && (cnt != num) && cred.a_valid && cred.b_valid;
		last = (cnt == num) || (take && t_count'(cnt + 1'b1) == num);
	end

	assign cred.pop = take;
	assign job.busy = (state == PE_RUN);
	assign job.done = (state == PE_DONE);
	assign job.result = acc;

	// --------------------
	// Accumulate FSM
	// --------------------
	always_ff @(posedge Clk_400)
	begin
		if (rst)
		begin
			state <= PE_IDLE;
			num <= '0;
			cnt <= '0;
			acc <= '0;
		end
		else
		begin
			case (state)
				PE_IDLE, PE_DONE:
				begin
					if (job.go)
					begin
						state <= PE_RUN;
						num <= job.num_elems;
						cnt <= '0;
						acc <= '0;
					end
					else
						state <= PE_IDLE;
				end
				PE_RUN:
				begin
					if (take)
					begin
						acc <= acc + t_acc'(prod);  // Wraps
						cnt <= cnt + 1'b1;
					end
					if (last)
						state <= PE_DONE;
				end
				default: state <= PE_IDLE;
			endcase
		end
	end

endmodule

// File: hw/mm_dot_operand_queue.sv
`include "mm_dot_macros.svh"

module mm_dot_operand_queue import mm_dot_pkg::*;
(
	input logic Clk_400,
	input logic rst,
	input logic push,
	input t_elem push_data,
	input logic pop,
	output t_elem head,
	output t_count count,
	output logic valid
);

	localparam int PTR_W = $clog2(`MM_QDEPTH);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`MM_QDEPTH - 1);

	t_elem mem [`MM_QDEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	assign head = mem[rd_ptr];
	assign valid = (count != '0);

	always_ff @(posedge Clk_400)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			count <= count + t_count'(push) - t_count'(pop);
		end
	end

	always_ff @(posedge Clk_400)
	begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	// Credit limit upstream keeps these from firing
	a_no_overflow: assert property (@(posedge Clk_400) disable iff (rst)
		push |-> (count != t_count'(`MM_QDEPTH)));
	a_no_underflow: assert property (@(posedge Clk_400) disable iff (rst)
		pop |-> valid);

endmodule

// File: hw/mm_dot_requestor.sv
`include "mm_dot_macros.svh"

module mm_dot_requestor import mm_dot_pkg::*;
(
	input logic Clk_400,
	input logic rst,
	job_if.requestor job,
	credit_if.requestor cred,
	output logic rd_req_valid,
	output t_addr rd_req_addr,
	output t_tag rd_req_tag,
	input logic rd_almfull
);

	t_req_state state;
	t_addr base_a;
	t_addr base_b;
	t_count num;
	t_count idx_a;      // Next element to request
	t_count idx_b;
	t_count pend_a;     // Requested, not yet popped
	t_count pend_b;
	logic turn_b;       // B goes next if it can
	logic want_a;
	logic want_b;
	logic sel_b;
	logic issue;
	t_count idx_sel;

	// --------------------
	// Operand pick
	// --------------------
	always_comb
	begin
		want_a = (idx_a != num) && (pend_a != t_count'(`MM_PEND_THRESH));
		want_b = (idx_b != num) && (pend_b != t_count'(`MM_PEND_THRESH));
		sel_b = want_b && (turn_b || !want_a);  // Fall over to the other side when stuck
		issue = (state == REQ_RUN) && !rd_almfull && (want_a || want_b);
		idx_sel = sel_b ? idx_b : idx_a;
	end

	assign rd_req_valid = issue;
	assign rd_req_addr = (sel_b ? base_b : base_a) + (t_addr'(idx_sel) << 2);
	assign rd_req_tag = {sel_b, idx_sel};

	always_ff @(posedge Clk_400)
	begin
		if (rst)
		begin
			state <= REQ_IDLE;
			num <= '0;
			idx_a <= '0;
			idx_b <= '0;
			pend_a <= '0;
			pend_b <= '0;
			turn_b <= 1'b0;
		end
		else
		begin
			// Up on issue, down on the shared pop
			pend_a <= pend_a + t_count'(issue && !sel_b) - t_count'(cred.pop);
			pend_b <= pend_b + t_count'(issue && sel_b) - t_count'(cred.pop);
			case (state)
				REQ_IDLE:
				begin
					if (job.go && job.num_elems != '0)
					begin
						state <= REQ_RUN;
						num <= job.num_elems;
						idx_a <= '0;
						idx_b <= '0;
						turn_b <= 1'b0;     // A first
					end
				end
				REQ_RUN:
				begin
					if (issue)
					begin
						if (sel_b)
							idx_b <= idx_b + 1'b1;
						else
							idx_a <= idx_a + 1'b1;
						turn_b <= !sel_b;
					end
					if (idx_a == num && idx_b == num)
						state <= REQ_IDLE;
				end
				default: state <= REQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge Clk_400)
	begin
		if (state == REQ_IDLE && job.go)
		begin
			base_a <= job.src_a;
			base_b <= job.src_b;
		end
	end

	a_no_req_almfull: assert property (@(posedge Clk_400) disable iff (rst)
		rd_almfull |-> !rd_req_valid);

	// Queued elements are a subset of the outstanding ones
	a_pend_covers_queue: assert property (@(posedge Clk_400) disable iff (rst)
		(pend_a >= cred.a_count) && (pend_b >= cred.b_count));

endmodule

// File: hw/mm_dot_csr.sv
`include "mm_dot_macros.svh"

module mm_dot_csr import mm_dot_pkg::*;
(
	input logic Clk_400,
	input logic rst,
	input logic mmio_wr_valid,
	input logic mmio_rd_valid,
	input t_mmio_addr mmio_addr,
	input t_mmio_data mmio_wdata,
	input logic [8:0] mmio_tid,
	output logic mmio_rsp_valid,
	output logic [8:0] mmio_rsp_tid,
	output t_mmio_data mmio_rsp_data,
	job_if.csr job
);

	t_addr src_a_q;
	t_addr src_b_q;
	t_count num_q;
	logic go_q;
	logic done_seen;    // Sticky until the next go
	logic start_req;
	t_mmio_data rd_data;

	// go_q also blocks here, busy only rises the cycle after go
	assign start_req = mmio_wr_valid && (mmio_addr == `MM_REG_CTL) && mmio_wdata[0] &&
		!job.busy && !go_q;

	assign job.go = go_q;
	assign job.src_a = src_a_q;
	assign job.src_b = src_b_q;
	assign job.num_elems = num_q;

	// --------------------
	// Register writes
	// --------------------
	always_ff @(posedge Clk_400)
	begin
		if (rst)
		begin
			src_a_q <= '0;
			src_b_q <= '0;
			num_q <= '0;
			go_q <= 1'b0;
			done_seen <= 1'b0;
		end
		else
		begin
			go_q <= start_req;
			if (mmio_wr_valid && mmio_addr == `MM_REG_SRC_A)
				src_a_q <= mmio_wdata[`MM_ADDR_W-1:0];
			if (mmio_wr_valid && mmio_addr == `MM_REG_SRC_B)
				src_b_q <= mmio_wdata[`MM_ADDR_W-1:0];
			if (mmio_wr_valid && mmio_addr == `MM_REG_NUM)
				num_q <= mmio_wdata[15:0];
			if (go_q)
				done_seen <= 1'b0;
			else if (job.done)
				done_seen <= 1'b1;
		end
	end

	// --------------------
	// Read mux and response
	// --------------------
	always_comb
	begin
		case (mmio_addr)
			`MM_REG_SRC_A: rd_data = t_mmio_data'(src_a_q);
			`MM_REG_SRC_B: rd_data = t_mmio_data'(src_b_q);
			`MM_REG_NUM: rd_data = t_mmio_data'(num_q);
			`MM_REG_STATUS: rd_data = {62'b0, done_seen, job.busy | go_q};
			`MM_REG_RESULT: rd_data = job.result;
			default: rd_data = '0;  // CTL and holes read as zero
		endcase
	end

	always_ff @(posedge Clk_400)
	begin
		if (rst)
			mmio_rsp_valid <= 1'b0;
		else
			mmio_rsp_valid <= mmio_rd_valid;
	end

	always_ff @(posedge Clk_400)
	begin
		mmio_rsp_tid <= mmio_tid;   // Echoed back with the data
		mmio_rsp_data <= rd_data;
	end

	// A start while the PE is running must be dropped
	a_go_not_busy: assert property (@(posedge Clk_400) disable iff (rst)
		job.go |-> !job.busy);

endmodule

// File: hw/mm_dot_ifs.sv
// Job control between register file, requestor and PE
interface job_if import mm_dot_pkg::*; ();
	logic go;           // One-cycle start
	t_addr src_a;
	t_addr src_b;
	t_count num_elems;
	logic busy;
	logic done;         // One-cycle pulse
	t_acc result;       // Held until the next go

	modport csr (output go, src_a, src_b, num_elems, input busy, done, result);
	modport requestor (input go, src_a, src_b, num_elems);
	modport pe (input go, num_elems, output busy, done, result);
endinterface

// Queue levels and the shared pop
interface credit_if import mm_dot_pkg::*; ();
	logic pop;          // Pops A and B together
	t_count a_count;
	t_count b_count;
	logic a_valid;
	logic b_valid;

	// Each pop hands back one credit per operand
	modport requestor (input pop, a_count, b_count);
	modport pe (output pop, input a_valid, b_valid);
endinterface

// File: hw/mm_dot_pkg.sv
`include "mm_dot_macros.svh"

package mm_dot_pkg;

	// --------------------
	// Datapath widths
	// --------------------
	typedef logic [`MM_ADDR_W-1:0] t_addr;  // Host element address
	typedef logic [31:0] t_elem;            // Element, treated as signed
	typedef logic [63:0] t_acc;             // Wraps at 64 bits
	typedef logic [15:0] t_count;           // Element count and index

	// MMIO side
	typedef logic [15:0] t_mmio_addr;
	typedef logic [63:0] t_mmio_data;

	// Bit 16 picks the operand (1 is B), bits 15:0 are the index
	typedef logic [16:0] t_tag;

	// --------------------
	// State machines
	// --------------------
	typedef enum logic
	{
		REQ_IDLE,
		REQ_RUN
	} t_req_state;

	typedef enum logic [1:0]
	{
		PE_IDLE,
		PE_RUN,
		PE_DONE     // One cycle, carries the done pulse
	} t_pe_state;

endpackage

// File: hw/mm_dot_macros.svh
`ifndef MM_DOT_MACROS_SVH
`define MM_DOT_MACROS_SVH

// --------------------
// Sizes
// --------------------
`define MM_ADDR_W       32      // Host element address, one 32-bit word per element
`define MM_QDEPTH       8       // Entries per operand queue
`define MM_PEND_THRESH  7       // Outstanding reads per operand, keep <= MM_QDEPTH

// --------------------
// Register map, byte offsets
// --------------------
`define MM_REG_SRC_A    16'h0000
`define MM_REG_SRC_B    16'h0008
`define MM_REG_NUM      16'h0010
`define MM_REG_CTL      16'h0018    // Bit 0 starts a job
`define MM_REG_STATUS   16'h0020    // Bit 0 busy, bit 1 done
`define MM_REG_RESULT   16'h0028

`endif
